//--- Bender.yml
package:
  name: acc_dispatcher

sources:
  - design/acc_disp_pkg.sv
  - design/acc_queue_if.sv
  - design/acc_insn_queue.sv
  - design/acc_spec_tracker.sv
  - design/acc_req_stage.sv
  - design/acc_mem_tracker.sv
  - design/acc_dispatcher.sv
  - target: test
    files:
      - tb/tb_acc_dispatcher.sv

//--- design/acc_disp_pkg.sv
// Accelerator dispatcher definitions
`default_nettype none

package acc_disp_pkg;

  // Functional unit of the instruction at the issue port
  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_ACCEL = 2'd3
  } fu_e;

  // Memory class of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_OTHER = 2'd0,
    ACC_OP_LOAD  = 2'd1,
    ACC_OP_STORE = 2'd2
  } acc_op_e;

  // Operand and result width
  parameter int XLEN = 32;

  // Transaction ID width, 2**TRANS_ID_BITS scoreboard entries
  parameter int TRANS_ID_BITS = 3;

  // Entries in the instruction queue
  parameter int QUEUE_DEPTH = 3;

  // Width of each load/store counter
  parameter int CNT_WIDTH = 3;

  // Raw instruction word, always 32 bits
  parameter int INSN_WIDTH = 32;

endpackage : acc_disp_pkg

`default_nettype wire

//--- design/acc_dispatcher.sv
// Accelerator dispatcher top level
`timescale 1ns/10ps
`default_nettype none

module acc_dispatcher
  import acc_disp_pkg::*;
#(
  parameter int XLen        = XLEN,
  parameter int TransIdBits = TRANS_ID_BITS,
  parameter int QueueDepth  = QUEUE_DEPTH,
  parameter int CntWidth    = CNT_WIDTH
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   flush_i,
  input  wire logic                   cons_en_i,
  // Issue stage
  input  wire logic                   issue_valid_i,
  input  wire fu_e                    issue_fu_i,
  input  wire acc_op_e                issue_op_i,
  input  wire logic [INSN_WIDTH-1:0]  issue_insn_i,
  input  wire logic [XLen-1:0]        issue_rs1_i,
  input  wire logic [XLen-1:0]        issue_rs2_i,
  input  wire logic [TransIdBits-1:0] issue_trans_id_i,
  output logic                        issue_stall_o,
  // Commit stage
  input  wire logic                   commit_valid_i,
  input  wire logic [TransIdBits-1:0] commit_trans_id_i,
  input  wire logic                   commit_st_barrier_i,
  output logic                        halt_o,
  // Accelerator request
  output logic                        acc_req_valid_o,
  input  wire logic                   acc_req_ready_i,
  output logic [INSN_WIDTH-1:0]       acc_req_insn_o,
  output logic [XLen-1:0]             acc_req_rs1_o,
  output logic [XLen-1:0]             acc_req_rs2_o,
  output logic [TransIdBits-1:0]      acc_req_trans_id_o,
  // Accelerator response
  input  wire logic                   acc_resp_valid_i,
  input  wire logic [TransIdBits-1:0] acc_resp_trans_id_i,
  input  wire logic [XLen-1:0]        acc_resp_result_i,
  input  wire logic                   acc_resp_load_complete_i,
  input  wire logic                   acc_resp_store_complete_i,
  input  wire logic                   acc_resp_store_pending_i,
  // Writeback
  output logic                        result_valid_o,
  output logic [TransIdBits-1:0]      result_trans_id_o,
  output logic [XLen-1:0]             result_o
);

  logic push;
  logic queue_ready;
  logic head_ready;

  acc_queue_if #(
    .XLen        (XLen),
    .TransIdBits (TransIdBits)
  ) queue_bus ();

  // Accepted accelerator issue enters the queue
  assign push = issue_valid_i & ~issue_stall_o & (issue_fu_i == FU_ACCEL);

  acc_insn_queue #(
    .XLen        (XLen),
    .TransIdBits (TransIdBits),
    .QueueDepth  (QueueDepth)
  ) insn_queue_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .push_i     (push),
    .insn_i     (issue_insn_i),
    .rs1_i      (issue_rs1_i),
    .rs2_i      (issue_rs2_i),
    .trans_id_i (issue_trans_id_i),
    .op_i       (issue_op_i),
    .ready_o    (queue_ready),
    .q          (queue_bus.queue)
  );

  acc_spec_tracker #(
    .TransIdBits (TransIdBits)
  ) spec_tracker_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .push_i            (push),
    .push_trans_id_i   (issue_trans_id_i),
    .commit_valid_i    (commit_valid_i),
    .commit_trans_id_i (commit_trans_id_i),
    .head_ready_o      (head_ready),
    .q                 (queue_bus.monitor)
  );

  acc_req_stage #(
    .XLen        (XLen),
    .TransIdBits (TransIdBits)
  ) req_stage_i (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .head_ready_i       (head_ready),
    .q                  (queue_bus.req),
    .acc_req_valid_o    (acc_req_valid_o),
    .acc_req_ready_i    (acc_req_ready_i),
    .acc_req_insn_o     (acc_req_insn_o),
    .acc_req_rs1_o      (acc_req_rs1_o),
    .acc_req_rs2_o      (acc_req_rs2_o),
    .acc_req_trans_id_o (acc_req_trans_id_o)
  );

  acc_mem_tracker #(
    .CntWidth (CntWidth)
  ) mem_tracker_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .cons_en_i        (cons_en_i),
    .issue_valid_i    (issue_valid_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .queue_ready_i    (queue_ready),
    .load_complete_i  (acc_resp_load_complete_i),
    .store_complete_i (acc_resp_store_complete_i),
    .store_pending_i  (acc_resp_store_pending_i),
    .st_barrier_i     (commit_st_barrier_i),
    .issue_stall_o    (issue_stall_o),
    .halt_o           (halt_o),
    .q                (queue_bus.monitor)
  );

  // Results go back to the core unchanged
  assign result_valid_o    = acc_resp_valid_i;
  assign result_trans_id_o = acc_resp_trans_id_i;
  assign result_o          = acc_resp_result_i;

endmodule : acc_dispatcher

`default_nettype wire

//--- design/acc_insn_queue.sv
// Accelerator instruction queue
`timescale 1ns/10ps
`default_nettype none

module acc_insn_queue
  import acc_disp_pkg::*;
#(
  parameter int XLen        = XLEN,
  parameter int TransIdBits = TRANS_ID_BITS,
  parameter int QueueDepth  = QUEUE_DEPTH
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   flush_i,
  input  wire logic                   push_i,
  input  wire logic [INSN_WIDTH-1:0]  insn_i,
  input  wire logic [XLen-1:0]        rs1_i,
  input  wire logic [XLen-1:0]        rs2_i,
  input  wire logic [TransIdBits-1:0] trans_id_i,
  input  wire acc_op_e                op_i,
  output logic                        ready_o,
  acc_queue_if.queue                  q
);

  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int UseWidth = $clog2(QueueDepth + 1);
  localparam logic [PtrWidth-1:0] LastIdx = PtrWidth'(QueueDepth - 1);

  // Entry storage
  logic [INSN_WIDTH-1:0]  insn_mem     [QueueDepth];
  logic [XLen-1:0]        rs1_mem      [QueueDepth];
  logic [XLen-1:0]        rs2_mem      [QueueDepth];
  logic [TransIdBits-1:0] trans_id_mem [QueueDepth];
  acc_op_e                op_mem       [QueueDepth];

  logic [PtrWidth-1:0] rd_ptr_q, wr_ptr_q;
  logic [UseWidth-1:0] usage_q;
  logic                do_push;

  // Not full, so an issue never has to wait on a pop
  assign ready_o = (usage_q != UseWidth'(QueueDepth));
  assign do_push = push_i & ready_o;

  // Head read straight from the storage
  assign q.head_valid    = (usage_q != '0);
  assign q.head_insn     = insn_mem[rd_ptr_q];
  assign q.head_rs1      = rs1_mem[rd_ptr_q];
  assign q.head_rs2      = rs2_mem[rd_ptr_q];
  assign q.head_trans_id = trans_id_mem[rd_ptr_q];
  assign q.head_op       = op_mem[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (q.pop) begin
        rd_ptr_q <= (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (do_push && !q.pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (q.pop && !do_push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      insn_mem[wr_ptr_q]     <= insn_i;
      rs1_mem[wr_ptr_q]      <= rs1_i;
      rs2_mem[wr_ptr_q]      <= rs2_i;
      trans_id_mem[wr_ptr_q] <= trans_id_i;
      op_mem[wr_ptr_q]       <= op_i;
    end
  end

endmodule : acc_insn_queue

`default_nettype wire

//--- design/acc_mem_tracker.sv
// Accelerator load/store tracking
`timescale 1ns/10ps
`default_nettype none

module acc_mem_tracker
  import acc_disp_pkg::*;
#(
  parameter int CntWidth = CNT_WIDTH
) (
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire logic    flush_i,
  input  wire logic    cons_en_i,
  input  wire logic    issue_valid_i,
  input  wire fu_e     issue_fu_i,
  input  wire acc_op_e issue_op_i,
  input  wire logic    queue_ready_i,
  input  wire logic    load_complete_i,
  input  wire logic    store_complete_i,
  input  wire logic    store_pending_i,
  input  wire logic    st_barrier_i,
  output logic         issue_stall_o,
  output logic         halt_o,
  acc_queue_if.monitor q
);

  logic [CntWidth-1:0] spec_ld_q, spec_st_q;
  logic [CntWidth-1:0] disp_ld_q, disp_st_q;
  logic                accel_issue;
  logic                issue_ld, issue_st;
  logic                disp_ld, disp_st;
  logic                ld_counted, st_counted;
  logic                wait_st_q;

  // Up/down step, both at once cancel out
  function automatic logic [CntWidth-1:0] cnt_step(input logic [CntWidth-1:0] cnt,
                                                   input logic inc,
                                                   input logic dec);
    logic [CntWidth-1:0] res;
    res = cnt;
    if (inc && !dec) begin
      res = cnt + 1'b1;
    end else if (dec && !inc) begin
      res = cnt - 1'b1;
    end
    return res;
  endfunction

  // Accepted accelerator issue and its memory class
  assign accel_issue = issue_valid_i & ~issue_stall_o & (issue_fu_i == FU_ACCEL);
  assign issue_ld    = accel_issue & (issue_op_i == ACC_OP_LOAD);
  assign issue_st    = accel_issue & (issue_op_i == ACC_OP_STORE);
  // Leaving the queue means dispatched
  assign disp_ld     = q.pop & (q.head_op == ACC_OP_LOAD);
  assign disp_st     = q.pop & (q.head_op == ACC_OP_STORE);

  assign ld_counted = (spec_ld_q != '0) | (disp_ld_q != '0);
  assign st_counted = (spec_st_q != '0) | (disp_st_q != '0);

  // Scalar memory ops wait for conflicting accelerator ones
  always_comb begin
    unique case (issue_fu_i)
      FU_ACCEL: issue_stall_o = ~queue_ready_i;
      FU_LOAD:  issue_stall_o = cons_en_i & st_counted;
      FU_STORE: issue_stall_o = cons_en_i & (ld_counted | st_counted);
      default:  issue_stall_o = 1'b0;
    endcase
  end

  // Speculative counts vanish on flush, dispatched ones do not
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      if (flush_i) begin
        spec_ld_q <= '0;
        spec_st_q <= '0;
      end else begin
        spec_ld_q <= cnt_step(spec_ld_q, issue_ld, disp_ld);
        spec_st_q <= cnt_step(spec_st_q, issue_st, disp_st);
      end
      disp_ld_q <= cnt_step(disp_ld_q, disp_ld, load_complete_i);
      disp_st_q <= cnt_step(disp_st_q, disp_st, store_complete_i);
    end
  end

  // Barrier holds the core until the accelerator drains its stores
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_st_q <= 1'b0;
    end else begin
      wait_st_q <= (wait_st_q | st_barrier_i) & store_pending_i;
    end
  end

  assign halt_o = wait_st_q;

endmodule : acc_mem_tracker

`default_nettype wire

//--- design/acc_queue_if.sv
// Instruction queue head interface
`timescale 1ns/10ps
`default_nettype none

interface acc_queue_if
  import acc_disp_pkg::*;
#(
  parameter int XLen        = XLEN,
  parameter int TransIdBits = TRANS_ID_BITS
) ();

  // Head entry, valid while the queue is not empty
  logic                   head_valid;
  logic [INSN_WIDTH-1:0]  head_insn;
  logic [XLen-1:0]        head_rs1;
  logic [XLen-1:0]        head_rs2;
  logic [TransIdBits-1:0] head_trans_id;
  acc_op_e                head_op;
  // Head leaves the queue at this edge
  logic                   pop;

  modport queue (
    output head_valid, head_insn, head_rs1, head_rs2, head_trans_id, head_op,
    input  pop
  );

  modport req (
    input  head_valid, head_insn, head_rs1, head_rs2, head_trans_id, head_op,
    output pop
  );

  modport monitor (
    input head_valid, head_insn, head_rs1, head_rs2, head_trans_id, head_op, pop
  );

endinterface : acc_queue_if

`default_nettype wire

//--- design/acc_req_stage.sv
// Accelerator request register
`timescale 1ns/10ps
`default_nettype none

module acc_req_stage
  import acc_disp_pkg::*;
#(
  parameter int XLen        = XLEN,
  parameter int TransIdBits = TRANS_ID_BITS
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   head_ready_i,
  acc_queue_if.req                    q,
  output logic                        acc_req_valid_o,
  input  wire logic                   acc_req_ready_i,
  output logic [INSN_WIDTH-1:0]       acc_req_insn_o,
  output logic [XLen-1:0]             acc_req_rs1_o,
  output logic [XLen-1:0]             acc_req_rs2_o,
  output logic [TransIdBits-1:0]      acc_req_trans_id_o
);

  logic                   valid_q;
  logic [INSN_WIDTH-1:0]  insn_q;
  logic [XLen-1:0]        rs1_q;
  logic [XLen-1:0]        rs2_q;
  logic [TransIdBits-1:0] trans_id_q;
  logic                   reg_free;
  logic                   load;

  // Register can take a new entry when empty or handing over this cycle
  assign reg_free = ~valid_q | acc_req_ready_i;
  // Only committed heads move into the register
  assign load     = q.head_valid & head_ready_i & reg_free;
  assign q.pop    = load;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (acc_req_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload held stable under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      insn_q     <= q.head_insn;
      rs1_q      <= q.head_rs1;
      rs2_q      <= q.head_rs2;
      trans_id_q <= q.head_trans_id;
    end
  end

  assign acc_req_valid_o    = valid_q;
  assign acc_req_insn_o     = insn_q;
  assign acc_req_rs1_o      = rs1_q;
  assign acc_req_rs2_o      = rs2_q;
  assign acc_req_trans_id_o = trans_id_q;

endmodule : acc_req_stage

`default_nettype wire

//--- design/acc_spec_tracker.sv
// Speculation tracker for queued instructions
`timescale 1ns/10ps
`default_nettype none

module acc_spec_tracker
  import acc_disp_pkg::*;
#(
  parameter int TransIdBits = TRANS_ID_BITS
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   flush_i,
  input  wire logic                   push_i,
  input  wire logic [TransIdBits-1:0] push_trans_id_i,
  input  wire logic                   commit_valid_i,
  input  wire logic [TransIdBits-1:0] commit_trans_id_i,
  output logic                        head_ready_o,
  acc_queue_if.monitor                q
);

  localparam int NumIds = 2 ** TransIdBits;

  // Received by the dispatcher but not yet committed
  logic [NumIds-1:0] pending_d, pending_q;
  // Committed and waiting to be dispatched
  logic [NumIds-1:0] ready_d, ready_q;
  logic              commit_hit;

  // Commit only counts for an ID the dispatcher holds
  assign commit_hit = commit_valid_i & pending_q[commit_trans_id_i];

  // Head may go once committed, including a commit in this very cycle
  assign head_ready_o = q.head_valid &
                        (ready_q[q.head_trans_id] |
                         (commit_hit & (commit_trans_id_i == q.head_trans_id)));

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // Commit moves the ID from pending to ready
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end
    // A popped head is no longer waiting
    if (q.pop) ready_d[q.head_trans_id] = 1'b0;
    // New instruction in the queue
    if (push_i) pending_d[push_trans_id_i] = 1'b1;
    // Flush drops everything the queue held
    if (flush_i) begin
      pending_d = '0;
      ready_d   = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule : acc_spec_tracker

`default_nettype wire

//--- tb/acc_dispatcher_tests.txt
# One command per line, fields in hex: T name | I fu op insn rs1 rs2 id | C id | F | B
# P pend | K ld st | M cons | R ready | Q n | D | X id result | V valid | E fu stall | H halt
T reset_state
V 0
H 0
E 3 0
T commit_gate
R 1
M 0
I 3 0 0000a00b 11111111 22222222 1
Q 5
V 0
C 1
V 1
D
X 1 cafef00d
T issue_order
R 2
I 3 0 0000100b 00000001 00000010 2
I 3 0 0000200b 00000002 00000020 3
C 2
C 3
I 3 0 0000300b 00000003 00000030 4
C 4
I 3 0 0000400b 00000004 00000040 5
I 3 0 0000500b 00000005 00000050 6
C 5
C 6
D
T flush_drop
M 1
I 3 2 0000600b 00000006 00000060 7
I 3 2 0000700b 00000007 00000070 0
E 2 1
F
Q 8
V 0
E 2 0
T load_after_store
R 1
M 1
I 3 2 0000800b 00000008 00000080 1
C 1
D
E 1 1
Q 3
E 1 1
K 0 1
E 1 0
M 0
I 3 2 0000900b 00000009 00000090 2
E 1 0
C 2
D
E 1 0
K 0 1
T queue_full
R 0
I 3 0 0000a00b 0000000a 000000a0 3
C 3
I 3 0 0000b00b 0000000b 000000b0 4
I 3 0 0000c00b 0000000c 000000c0 5
I 3 0 0000d00b 0000000d 000000d0 6
C 4
C 5
C 6
E 3 1
V 1
R 1
D
E 3 0
T store_barrier
P 1
H 0
B
H 1
Q 2
H 1
P 0
H 1
Q 1
H 0

//--- tb/tb_acc_dispatcher.sv
// Accelerator dispatcher testbench
`timescale 1ns/10ps
`default_nettype none

module tb_acc_dispatcher
  import acc_disp_pkg::*;
();

  localparam int XLen        = XLEN;
  localparam int TransIdBits = TRANS_ID_BITS;
  localparam int IssueLimit  = 100;
  localparam int DrainLimit  = 200;

  logic                   clk_i, rst_i, flush_i, cons_en_i;
  logic                   issue_valid_i, issue_stall_o;
  fu_e                    issue_fu_i;
  acc_op_e                issue_op_i;
  logic [INSN_WIDTH-1:0]  issue_insn_i;
  logic [XLen-1:0]        issue_rs1_i, issue_rs2_i;
  logic [TransIdBits-1:0] issue_trans_id_i, commit_trans_id_i;
  logic                   commit_valid_i, commit_st_barrier_i, halt_o;
  logic                   acc_req_valid_o, acc_req_ready_i;
  logic [INSN_WIDTH-1:0]  acc_req_insn_o;
  logic [XLen-1:0]        acc_req_rs1_o, acc_req_rs2_o;
  logic [TransIdBits-1:0] acc_req_trans_id_o, acc_resp_trans_id_i, result_trans_id_o;
  logic                   acc_resp_valid_i, acc_resp_load_complete_i;
  logic                   acc_resp_store_complete_i, acc_resp_store_pending_i;
  logic [XLen-1:0]        acc_resp_result_i, result_o;
  logic                   result_valid_o;

  // Accelerator instructions still owed to the accelerator in issue order
  logic [INSN_WIDTH-1:0]  exp_insn[$];
  logic [XLen-1:0]        exp_rs1[$];
  logic [XLen-1:0]        exp_rs2[$];
  logic [TransIdBits-1:0] exp_id[$];
  bit                     exp_committed[$];

  // Request left waiting at the last mid-cycle sample
  logic                   held;

  integer                 seed = 58928;
  int                     ready_mode;
  int                     checks, errors, passed, failed;

  acc_dispatcher acc_dispatcher_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Accelerator ready held low in mode 0, held high in mode 1 and random otherwise
  always @(posedge clk_i) begin
    int          mode;
    logic [31:0] rnd;
    // Mode taken at the edge so a new mode applies from the next cycle on
    mode = ready_mode;
    #1;
    if (mode == 0) begin
      acc_req_ready_i = 1'b0;
    end else if (mode == 1) begin
      acc_req_ready_i = 1'b1;
    end else begin
      rnd = $random(seed);
      acc_req_ready_i = rnd[0];
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Presented request must be the oldest outstanding instruction
  task automatic check_request(input bit transfer);
    assert (exp_id.size() != 0) else begin
      $display("Error at %0t: request presented with nothing outstanding", $time);
      errors++;
    end
    if (exp_id.size() != 0) begin
      assert (exp_committed[0]) else begin
        $display("Error at %0t: trans_id %0d presented before its commit", $time, exp_id[0]);
        errors++;
      end
      check_value("acc_req_insn_o", acc_req_insn_o, exp_insn[0]);
      check_value("acc_req_rs1_o", acc_req_rs1_o, exp_rs1[0]);
      check_value("acc_req_rs2_o", acc_req_rs2_o, exp_rs2[0]);
      check_value("acc_req_trans_id_o", acc_req_trans_id_o, exp_id[0]);
      // Accepted entry is owed no longer
      if (transfer) begin
        void'(exp_insn.pop_front());
        void'(exp_rs1.pop_front());
        void'(exp_rs2.pop_front());
        void'(exp_id.pop_front());
        void'(exp_committed.pop_front());
      end
    end
  endtask

  // Mid-cycle sample of the request port for the transfer at the next rising edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      held = 1'b0;
    end else begin
      // Valid stays up until the accelerator takes the request
      if (held) begin
        check_value("acc_req_valid_o", acc_req_valid_o, 1'b1);
      end
      if (acc_req_valid_o) begin
        check_request(acc_req_ready_i);
      end
      held = acc_req_valid_o && !acc_req_ready_i;
    end
  end

  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_issue(input logic [31:0] fu, op, insn, rs1, rs2, id);
    int cnt;
    step_cycle();
    issue_valid_i    = 1'b1;
    issue_fu_i       = fu_e'(fu[1:0]);
    issue_op_i       = acc_op_e'(op[1:0]);
    issue_insn_i     = insn;
    issue_rs1_i      = rs1;
    issue_rs2_i      = rs2;
    issue_trans_id_i = id[TransIdBits-1:0];
    #1;
    cnt = 0;
    // Wait for room while the queue is full
    while (issue_stall_o && cnt < IssueLimit) begin
      @(posedge clk_i);
      #2;
      cnt++;
    end
    assert (!issue_stall_o) else begin
      $display("Error at %0t: issue of trans_id %0d stalled too long", $time, id);
      errors++;
      issue_valid_i = 1'b0;
    end
    // Accepted accelerator issue is owed to the accelerator
    if (issue_valid_i && fu[1:0] == FU_ACCEL) begin
      exp_insn.push_back(insn);
      exp_rs1.push_back(rs1);
      exp_rs2.push_back(rs2);
      exp_id.push_back(id[TransIdBits-1:0]);
      exp_committed.push_back(1'b0);
    end
    // Accept edge
    step_cycle();
    issue_valid_i = 1'b0;
  endtask

  task automatic drive_commit(input logic [31:0] id);
    bit found;
    step_cycle();
    commit_valid_i    = 1'b1;
    commit_trans_id_i = id[TransIdBits-1:0];
    found = 1'b0;
    // Oldest uncommitted entry with this ID becomes sendable
    foreach (exp_id[i]) begin
      if (!found && exp_id[i] == id[TransIdBits-1:0] && !exp_committed[i]) begin
        exp_committed[i] = 1'b1;
        found = 1'b1;
      end
    end
    // Single-cycle commit pulse
    step_cycle();
    commit_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while ((exp_id.size() != 0 || acc_req_valid_o) && cnt < DrainLimit) begin
      step_cycle();
      cnt++;
    end
    assert (exp_id.size() == 0 && !acc_req_valid_o) else begin
      $display("Error at %0t: %0d requests never reached the accelerator",
               $time, exp_id.size());
      errors++;
    end
  endtask

  initial begin : main
    int                fd;
    int                n;
    int                test_open;
    int                test_err_base;
    logic [7:0]        cmd;
    logic [8*32-1:0]   test_name;
    logic [8*128-1:0]  skip_buf;
    logic [31:0]       v0, v1, v2, v3, v4, v5;

    rst_i = 1'b1;
    flush_i = 1'b0;
    cons_en_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_fu_i = FU_NONE;
    issue_op_i = ACC_OP_OTHER;
    issue_insn_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    issue_trans_id_i = '0;
    commit_valid_i = 1'b0;
    commit_trans_id_i = '0;
    commit_st_barrier_i = 1'b0;
    acc_req_ready_i = 1'b0;
    acc_resp_valid_i = 1'b0;
    acc_resp_trans_id_i = '0;
    acc_resp_result_i = '0;
    acc_resp_load_complete_i = 1'b0;
    acc_resp_store_complete_i = 1'b0;
    acc_resp_store_pending_i = 1'b0;
    ready_mode = 0;
    test_open = 0;
    test_err_base = 0;
    test_name = '0;

    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    fd = $fopen("tb/acc_dispatcher_tests.txt", "r");
    assert (fd != 0) else begin
      $display("Error: cannot open the test command file");
      errors++;
    end

    // One command letter per line, its values follow
    while (fd != 0 && $fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": n = $fgets(skip_buf, fd);
        "T": begin
          // Report the finished test, then open the next one
          if (test_open != 0) begin
            if (errors == test_err_base) begin
              passed++;
              $display("Test %0s ok", test_name);
            end else begin
              failed++;
              $display("Test %0s failed, %0d errors", test_name, errors - test_err_base);
            end
          end
          n = $fscanf(fd, "%s", test_name);
          test_open = 1;
          test_err_base = errors;
        end
        "I": begin
          n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
          drive_issue(v0, v1, v2, v3, v4, v5);
        end
        "C": begin
          n = $fscanf(fd, "%h", v0);
          drive_commit(v0);
        end
        "F": begin
          step_cycle();
          flush_i = 1'b1;
          // Uncommitted work is discarded
          exp_insn.delete();
          exp_rs1.delete();
          exp_rs2.delete();
          exp_id.delete();
          exp_committed.delete();
          step_cycle();
          flush_i = 1'b0;
        end
        "B": begin
          // One-cycle store barrier at commit
          step_cycle();
          commit_st_barrier_i = 1'b1;
          step_cycle();
          commit_st_barrier_i = 1'b0;
        end
        "P": begin
          n = $fscanf(fd, "%h", v0);
          step_cycle();
          acc_resp_store_pending_i = v0[0];
        end
        "K": begin
          // Completion pulses from the accelerator
          n = $fscanf(fd, "%h %h", v0, v1);
          step_cycle();
          acc_resp_load_complete_i  = v0[0];
          acc_resp_store_complete_i = v1[0];
          step_cycle();
          acc_resp_load_complete_i  = 1'b0;
          acc_resp_store_complete_i = 1'b0;
        end
        "M": begin
          n = $fscanf(fd, "%h", v0);
          step_cycle();
          cons_en_i = v0[0];
        end
        "R": begin
          n = $fscanf(fd, "%h", v0);
          ready_mode = v0;
        end
        "Q": begin
          n = $fscanf(fd, "%h", v0);
          repeat (v0) step_cycle();
        end
        "D": wait_drain();
        "X": begin
          n = $fscanf(fd, "%h %h", v0, v1);
          step_cycle();
          acc_resp_valid_i    = 1'b1;
          acc_resp_trans_id_i = v0[TransIdBits-1:0];
          acc_resp_result_i   = v1;
          #1;
          // Response reaches the core in the same cycle
          check_value("result_valid_o", result_valid_o, 1'b1);
          check_value("result_trans_id_o", result_trans_id_o, v0[TransIdBits-1:0]);
          check_value("result_o", result_o, v1);
          step_cycle();
          acc_resp_valid_i = 1'b0;
          #1;
          // And drops with it
          check_value("result_valid_o", result_valid_o, 1'b0);
        end
        "V": begin
          n = $fscanf(fd, "%h", v0);
          check_value("acc_req_valid_o", acc_req_valid_o, v0[0]);
        end
        "E": begin
          // Stall seen by an issue of the given unit
          n = $fscanf(fd, "%h %h", v0, v1);
          step_cycle();
          issue_valid_i = 1'b0;
          issue_fu_i    = fu_e'(v0[1:0]);
          #1;
          check_value("issue_stall_o", issue_stall_o, v1[0]);
        end
        "H": begin
          n = $fscanf(fd, "%h", v0);
          check_value("halt_o", halt_o, v0[0]);
        end
        default: begin
          $display("Error: unknown command %c in the test file", cmd);
          errors++;
        end
      endcase
    end

    if (test_open != 0) begin
      if (errors == test_err_base) begin
        passed++;
        $display("Test %0s ok", test_name);
      end else begin
        failed++;
        $display("Test %0s failed, %0d errors", test_name, errors - test_err_base);
      end
    end
    $display("Tests %0d passed, %0d failed; checks %0d, errors %0d",
             passed, failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Whole run bound
  initial begin : watchdog
    #2_000_000;
    $display("Error: simulation did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_acc_dispatcher

`default_nettype wire

//--- vlog.f
design/acc_disp_pkg.sv
design/acc_queue_if.sv
design/acc_insn_queue.sv
design/acc_spec_tracker.sv
design/acc_req_stage.sv
design/acc_mem_tracker.sv
design/acc_dispatcher.sv
tb/tb_acc_dispatcher.sv
